//--- flist.f
eeprom_pkg.sv
cmd_fifo.sv
eeprom_master.sv
serial_eeprom.sv
eeprom_subsys.sv
eeprom_assertions.sv
tb_eeprom.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the EEPROM testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_eeprom -f flist.f -o tb_eeprom
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_eeprom +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
    exit 1
fi
exit 0

//--- tb_eeprom.sv
module tb_eeprom;

    localparam int FIFO_DEPTH = 4;
    localparam int SCL_HALF   = 4;
    localparam int N_CMDS     = 48;
    localparam int CMD_CYCLES = 40 * 2 * SCL_HALF;   // a read is the longest command

    logic                    CLK;
    logic                    RESET;
    logic                    cmd_stb;
    eeprom_pkg::eeprom_cmd_t cmd;
    logic                    wp;
    logic                    rsp_stb;
    eeprom_pkg::eeprom_rsp_t rsp;
    logic                    overflow;
    logic                    busy;
    logic                    scl;
    logic                    sda;

    logic [7:0]              shadow [2048];
    logic [10:0]             used_addr [$];
    eeprom_pkg::eeprom_rsp_t exp_q [$];
    string                   name_q [$];
    logic [31:0]             rng = 32'h870825ac;
    int                      check_errs = 0;
    int                      missing = 0;
    int                      unexpected = 0;
    int                      total;

    eeprom_subsys #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .SCL_HALF   (SCL_HALF)
    ) u_dut (
        .CLK      (CLK),
        .RESET    (RESET),
        .cmd_stb  (cmd_stb),
        .cmd      (cmd),
        .wp       (wp),
        .rsp_stb  (rsp_stb),
        .rsp      (rsp),
        .overflow (overflow),
        .busy     (busy),
        .scl      (scl),
        .sda      (sda)
    );

    always #5 CLK = ~CLK;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic compare_value(input string test, input string field,
                                 input logic [31:0] expv, input logic [31:0] actv);
        assert (expv == actv)
        else
        begin
            $display("FAILED %s %s: expected %0h actual %0h", test, field, expv, actv);
            check_errs++;
        end
    endtask

    // expected response is fixed at issue time since commands run in order
    task automatic send(input string test, input logic is_read, input logic [10:0] addr,
                        input logic [7:0] wdata, input logic accepted);
        eeprom_pkg::eeprom_rsp_t e;
        @(negedge CLK);
        cmd_stb = 1'b1;
        cmd     = '{is_read, addr, wdata};
        e       = '{is_read, addr, shadow[addr], wp && !is_read};
        if (accepted)
        begin
            if (!is_read && !wp)
                shadow[addr] = wdata;
            exp_q.push_back(e);
            name_q.push_back(test);
        end
    endtask

    task automatic end_strobe();
        @(negedge CLK);
        cmd_stb = 1'b0;
    endtask

    task automatic wait_done(input string test);
        int cycles;
        int limit;
        cycles = 0;
        limit  = (exp_q.size() + 1) * CMD_CYCLES * 2;
        while ((exp_q.size() != 0 || busy) && cycles < limit)
        begin
            @(negedge CLK);
            cycles++;
        end
        if (exp_q.size() != 0)
        begin
            $display("%s: no response for %0d commands", test, exp_q.size());
            missing += exp_q.size();
            exp_q.delete();
            name_q.delete();
        end
        assert (scl && sda)
        else
        begin
            $display("%s: bus not idle high after the commands finished", test);
            check_errs++;
        end
    endtask

    always @(posedge CLK)
    begin
        eeprom_pkg::eeprom_rsp_t e;
        string                   n;
        if (!RESET && rsp_stb)
        begin
            if (exp_q.size() == 0)
            begin
                $display("response for address %h arrived with no command pending", rsp.addr);
                unexpected++;
            end
            else
            begin
                e = exp_q.pop_front();
                n = name_q.pop_front();
                compare_value(n, "was_read", e.was_read, rsp.was_read);
                compare_value(n, "addr", e.addr, rsp.addr);
                compare_value(n, "ack_err", e.ack_err, rsp.ack_err);
                if (e.was_read)
                    compare_value(n, "rdata", e.rdata, rsp.rdata);
            end
        end
    end

    initial
    begin
        logic [10:0] a;
        logic [7:0]  d;
        logic [7:0]  offset;
        CLK     = 1'b0;
        RESET   = 1'b1;
        cmd_stb = 1'b0;
        cmd     = '0;
        wp      = 1'b0;
        repeat (4) @(posedge CLK);
        @(negedge CLK);
        RESET = 1'b0;
        assert (scl && sda && !busy && !overflow && !rsp_stb)
        else
        begin
            $display("bus or status flags not idle after reset");
            check_errs++;
        end

        // each group of eight writes puts one offset in every block
        for (int i = 0; i < 16; i++)
        begin
            rng = lcg_step(rng);
            if (i % 8 == 0)
                offset = rng[15:8];
            a   = {3'(i % 8), offset};
            used_addr.push_back(a);
            send("write_read", 1'b0, a, rng[23:16], 1'b1);
            end_strobe();
            wait_done("write_read");
        end
        foreach (used_addr[i])
        begin
            send("write_read", 1'b1, used_addr[i], 8'h00, 1'b1);
            end_strobe();
            wait_done("write_read");
        end

        // FIFO_DEPTH strobes on back to back cycles
        rng = lcg_step(rng);
        a   = rng[10:0];
        d   = rng[31:24];
        send("queued", 1'b0, a, d, 1'b1);
        send("queued", 1'b0, a ^ 11'h400, ~d, 1'b1);
        send("queued", 1'b1, a, 8'h00, 1'b1);
        send("queued", 1'b1, a ^ 11'h400, 8'h00, 1'b1);
        end_strobe();
        wait_done("queued");

        // buffer fills behind a write in flight so the last two get dropped
        compare_value("overflow", "overflow before", 0, overflow);
        rng = lcg_step(rng);
        send("overflow", 1'b0, used_addr[0], rng[7:0], 1'b1);
        end_strobe();
        while (!busy)
            @(negedge CLK);
        for (int i = 0; i < FIFO_DEPTH + 2; i++)
            send("overflow", 1'b1, used_addr[i], 8'h00, i < FIFO_DEPTH);
        end_strobe();
        wait_done("overflow");
        compare_value("overflow", "overflow after", 1, overflow);

        @(negedge CLK);
        wp = 1'b1;
        send("write_protect", 1'b0, used_addr[1], ~shadow[used_addr[1]], 1'b1);
        end_strobe();
        wait_done("write_protect");
        wp = 1'b0;
        send("write_protect", 1'b1, used_addr[1], 8'h00, 1'b1);
        end_strobe();
        wait_done("write_protect");

        total = check_errs + missing + unexpected + u_dut.u_assert.fail_cnt;
        $display("errors: %0d check, %0d missing responses, %0d unexpected responses, %0d protocol",
                 check_errs, missing, unexpected, u_dut.u_assert.fail_cnt);
        if (total == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

    initial
    begin
        #(N_CMDS * CMD_CYCLES * 2 * 10);
        $display("watchdog expired, the run took longer than %0d commands allow", N_CMDS);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

//--- eeprom_assertions.sv
module eeprom_assertions (
    input logic CLK,
    input logic RESET,
    input logic rsp_stb,
    input logic busy,
    input logic scl,
    input logic sda,
    input logic overflow
);

    int         fail_cnt = 0;    // failed assertions
    logic       scl_q;
    logic       sda_q;
    logic [5:0] rises;           // scl rising edges since the last START or STOP
    logic       hi_edge;

    // sda moving while scl stays high is a START or a STOP
    assign hi_edge = scl && scl_q && (sda != sda_q);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            scl_q <= 1'b1;
            sda_q <= 1'b1;
            rises <= '0;
        end
        else
        begin
            scl_q <= scl;
            sda_q <= sda;
            if (hi_edge)
                rises <= '0;
            else if (scl && !scl_q)
                rises <= rises + 6'd1;
        end
    end

    // one strobe per finished command
    rsp_one_cycle: assert property (@(posedge CLK) disable iff (RESET) rsp_stb |=> !rsp_stb)
    else
    begin
        $error("rsp_stb held high for more than one cycle");
        fail_cnt++;
    end

    // START/STOP only from an idle bus or just after a nine-bit cell
    sda_stable_high: assert property (@(posedge CLK) disable iff (RESET)
        hi_edge |-> (rises == 6'd0 || (rises % 9) == 1))
    else
    begin
        $error("sda changed while scl was high outside a START or STOP");
        fail_cnt++;
    end

    bus_idle_high: assert property (@(posedge CLK) disable iff (RESET) !busy |-> (scl && sda))
    else
    begin
        $error("scl or sda low while the master is idle");
        fail_cnt++;
    end

    overflow_sticky: assert property (@(posedge CLK)
        ($past(overflow) && !overflow) |-> $past(RESET))
    else
    begin
        $error("overflow cleared without a reset");
        fail_cnt++;
    end

endmodule

bind eeprom_subsys eeprom_assertions u_assert (
    .CLK      (CLK),
    .RESET    (RESET),
    .rsp_stb  (rsp_stb),
    .busy     (busy),
    .scl      (scl),
    .sda      (sda),
    .overflow (overflow)
);

//--- eeprom_subsys.sv
module eeprom_subsys #(
    parameter int FIFO_DEPTH = 4,
    parameter int SCL_HALF   = 4
) (
    input  logic                     CLK,
    input  logic                     RESET,
    input  logic                     cmd_stb,
    input  eeprom_pkg::eeprom_cmd_t  cmd,
    input  logic                     wp,
    output logic                     rsp_stb,
    output eeprom_pkg::eeprom_rsp_t  rsp,
    output logic                     overflow,
    output logic                     busy,
    output logic                     scl,
    output logic                     sda
);

    eeprom_pkg::eeprom_cmd_t head;
    logic                    not_empty;
    logic                    pop;
    logic                    m_sda_low;
    logic                    s_sda_low;

    // open-drain bus, either side can pull low
    assign sda = !(m_sda_low || s_sda_low);

    cmd_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .CLK       (CLK),
        .RESET     (RESET),
        .push      (cmd_stb),
        .push_cmd  (cmd),
        .pop       (pop),
        .head      (head),
        .not_empty (not_empty),
        .overflow  (overflow)
    );

    eeprom_master #(
        .SCL_HALF (SCL_HALF)
    ) u_master (
        .CLK       (CLK),
        .RESET     (RESET),
        .cmd_ready (not_empty),
        .cmd       (head),
        .pop       (pop),
        .rsp_stb   (rsp_stb),
        .rsp       (rsp),
        .busy      (busy),
        .scl       (scl),
        .sda_low   (m_sda_low),
        .sda_in    (sda)
    );

    serial_eeprom u_mem (
        .CLK     (CLK),
        .RESET   (RESET),
        .scl     (scl),
        .sda_in  (sda),
        .wp      (wp),
        .sda_low (s_sda_low)
    );

endmodule

//--- serial_eeprom.sv
module serial_eeprom (
    input  logic CLK,
    input  logic RESET,
    input  logic scl,
    input  logic sda_in,
    input  logic wp,
    output logic sda_low
);

    typedef enum logic [2:0] {
        md_idle,
        md_ctrl,
        md_addr,
        md_wdata,
        md_tx
    } mode_t;

    logic [7:0]            mem [2048];
    mode_t                 mode;
    logic [10:0]           ptr;
    logic [3:0]            bit_cnt;
    eeprom_pkg::bus_byte_u rx_q;
    logic                  scl_d;
    logic                  sda_d;
    logic                  rise;
    logic                  fall;
    logic                  start_c;
    logic                  stop_c;
    logic                  ack_slot;
    logic                  hit;

    assign rise     = scl && !scl_d;
    assign fall     = !scl && scl_d;
    assign start_c  = scl && scl_d && sda_d && !sda_in;
    assign stop_c   = scl && scl_d && !sda_d && sda_in;
    assign ack_slot = fall && (bit_cnt == 4'd8);   // ninth low phase begins
    assign hit      = (rx_q.ctrl.dev_code == eeprom_pkg::DEV_CODE);

    always_ff @(posedge CLK)
    begin
        if (rise && bit_cnt != 4'd8)
            rx_q.raw <= {rx_q.raw[6:0], sda_in};
        else if (ack_slot && mode == md_ctrl && hit && rx_q.ctrl.rw)
            rx_q.raw <= mem[ptr];                    // byte to send back
        if (ack_slot && mode == md_wdata && !wp)
            mem[ptr] <= rx_q.raw;
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            scl_d   <= 1'b1;
            sda_d   <= 1'b1;
            mode    <= md_idle;
            bit_cnt <= '0;
            sda_low <= 1'b0;
            ptr     <= '0;
        end
        else
        begin
            scl_d <= scl;
            sda_d <= sda_in;
            if (start_c)
            begin
                mode    <= md_ctrl;
                bit_cnt <= '0;
                sda_low <= 1'b0;
            end
            else if (stop_c)
            begin
                mode    <= md_idle;
                bit_cnt <= '0;
                sda_low <= 1'b0;
            end
            else if (rise)
                bit_cnt <= (bit_cnt == 4'd8) ? 4'd0 : bit_cnt + 4'd1;
            else if (ack_slot)
            begin
                case (mode)
                    md_ctrl:
                    begin
                        sda_low <= hit;
                        if (!hit)
                            mode <= md_idle;   // not our device code
                        else if (rx_q.ctrl.rw)
                        begin
                            mode <= md_tx;
                            ptr  <= ptr + 11'd1;
                        end
                        else
                        begin
                            mode      <= md_addr;
                            ptr[10:8] <= rx_q.ctrl.blk;
                        end
                    end
                    md_addr:
                    begin
                        sda_low  <= 1'b1;
                        ptr[7:0] <= rx_q.raw;
                        mode     <= md_wdata;
                    end
                    md_wdata:
                    begin
                        sda_low <= !wp;    // protected write is refused
                        mode    <= md_idle;
                    end
                    default:
                    begin
                        sda_low <= 1'b0;   // master acks or nacks the read byte
                        mode    <= md_idle;
                    end
                endcase
            end
            else if (fall)
                sda_low <= (mode == md_tx) && !rx_q.raw[7];
        end
    end

endmodule

//--- eeprom_master.sv
module eeprom_master #(
    parameter int SCL_HALF = 4
) (
    input  logic                     CLK,
    input  logic                     RESET,
    input  logic                     cmd_ready,
    input  eeprom_pkg::eeprom_cmd_t  cmd,
    output logic                     pop,
    output logic                     rsp_stb,
    output eeprom_pkg::eeprom_rsp_t  rsp,
    output logic                     busy,
    output logic                     scl,
    output logic                     sda_low,
    input  logic                     sda_in
);

    // one bus bit takes 2*SCL_HALF clocks, scl low in the first half
    localparam int CW = $clog2(2 * SCL_HALF);
    localparam logic [CW-1:0] MID_LOW  = CW'(SCL_HALF / 2);
    localparam logic [CW-1:0] SCL_UP   = CW'(SCL_HALF - 1);
    localparam logic [CW-1:0] SAMPLE   = CW'(SCL_HALF);      // first clock with scl high
    localparam logic [CW-1:0] MID_HIGH = CW'(SCL_HALF + SCL_HALF / 2);
    localparam logic [CW-1:0] LAST     = CW'(2 * SCL_HALF - 1);

    typedef enum logic [3:0] {
        st_idle,
        st_start,
        st_ctrl,
        st_addr,
        st_data,
        st_restart,
        st_rctrl,
        st_read,
        st_nack,
        st_stop,
        st_resp
    } state_t;

    state_t                   state;
    logic [CW-1:0]            cnt;
    logic [3:0]               bit_cnt;
    eeprom_pkg::bus_byte_u    shreg;
    eeprom_pkg::eeprom_cmd_t  cmd_q;
    logic [7:0]               rdata_q;
    logic                     ack_err_q;
    logic                     send_st;
    logic                     cell_end;

    assign send_st  = (state == st_ctrl) || (state == st_addr) ||
                      (state == st_data) || (state == st_rctrl);
    assign cell_end = (cnt == LAST);

    assign pop     = (state == st_idle) && cmd_ready;
    assign busy    = (state != st_idle);
    assign rsp_stb = (state == st_resp);
    assign rsp     = eeprom_pkg::eeprom_rsp_t'{cmd_q.is_read, cmd_q.addr, rdata_q, ack_err_q};

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state   <= st_idle;
            cnt     <= '0;
            bit_cnt <= '0;
            scl     <= 1'b1;
            sda_low <= 1'b0;
        end
        else
        begin
            case (state)
                st_idle:
                begin
                    if (cmd_ready)
                    begin
                        state <= st_start;
                        cnt   <= '0;
                    end
                end
                st_resp: state <= st_idle;
                default:
                begin
                    cnt <= cell_end ? '0 : cnt + 1'b1;
                    if (cnt == SCL_UP)
                        scl <= 1'b1;
                    if (cell_end && state != st_stop)
                        scl <= 1'b0;   // bus stays high after STOP

                    // data changes mid low, START/STOP edges mid high
                    if (cnt == MID_LOW)
                    begin
                        if (state == st_stop)
                            sda_low <= 1'b1;
                        else if (send_st)
                            sda_low <= (bit_cnt != 4'd8) && !shreg.raw[7];
                        else
                            sda_low <= 1'b0;
                    end
                    if (cnt == MID_HIGH)
                    begin
                        if (state == st_start || state == st_restart)
                            sda_low <= 1'b1;
                        else if (state == st_stop)
                            sda_low <= 1'b0;
                    end

                    if (cell_end)
                    begin
                        case (state)
                            st_start:
                            begin
                                state   <= st_ctrl;
                                bit_cnt <= '0;
                            end
                            st_restart:
                            begin
                                state   <= st_rctrl;
                                bit_cnt <= '0;
                            end
                            st_ctrl, st_addr, st_data, st_rctrl:
                            begin
                                if (bit_cnt != 4'd8)
                                    bit_cnt <= bit_cnt + 4'd1;
                                else
                                begin
                                    bit_cnt <= '0;
                                    if (ack_err_q)
                                        state <= st_stop;    // abort on NACK
                                    else
                                    begin
                                        case (state)
                                            st_ctrl: state <= st_addr;
                                            st_addr: state <= cmd_q.is_read ? st_restart : st_data;
                                            st_rctrl: state <= st_read;
                                            default: state <= st_stop;
                                        endcase
                                    end
                                end
                            end
                            st_read:
                            begin
                                if (bit_cnt == 4'd7)
                                begin
                                    state   <= st_nack;
                                    bit_cnt <= '0;
                                end
                                else
                                    bit_cnt <= bit_cnt + 4'd1;
                            end
                            st_nack: state <= st_stop;
                            default: state <= st_resp;    // end of stop
                        endcase
                    end
                end
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (pop)
        begin
            cmd_q     <= cmd;
            ack_err_q <= 1'b0;
        end
        if (cnt == SAMPLE && send_st && bit_cnt == 4'd8 && sda_in)
            ack_err_q <= 1'b1;
        if (cnt == SAMPLE && state == st_read)
            rdata_q <= {rdata_q[6:0], sda_in};
        if (cell_end)
        begin
            if (state == st_start)
                shreg.ctrl <= eeprom_pkg::ctrl_byte_t'{eeprom_pkg::DEV_CODE,
                                                       cmd_q.addr[10:8], 1'b0};
            else if (state == st_restart)
                shreg.ctrl <= eeprom_pkg::ctrl_byte_t'{eeprom_pkg::DEV_CODE,
                                                       cmd_q.addr[10:8], 1'b1};
            else if (send_st && bit_cnt != 4'd8)
                shreg.raw <= {shreg.raw[6:0], 1'b0};
            else if (state == st_ctrl)
                shreg.raw <= cmd_q.addr[7:0];
            else if (state == st_addr)
                shreg.raw <= cmd_q.wdata;
        end
    end

endmodule

//--- cmd_fifo.sv
module cmd_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                     CLK,
    input  logic                     RESET,
    input  logic                     push,
    input  eeprom_pkg::eeprom_cmd_t  push_cmd,
    input  logic                     pop,
    output eeprom_pkg::eeprom_cmd_t  head,
    output logic                     not_empty,
    output logic                     overflow
);

    localparam int PW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CW = $clog2(FIFO_DEPTH + 1);

    eeprom_pkg::eeprom_cmd_t mem [FIFO_DEPTH];

    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          full;
    logic          do_push;
    logic          do_pop;

    assign not_empty = (count != '0);
    assign full      = (count == CW'(FIFO_DEPTH));
    assign do_pop    = pop && not_empty;
    assign do_push   = push && (!full || do_pop); // pop frees a slot on the same edge
    assign head      = mem[rd_ptr];

    always_ff @(posedge CLK)
    begin
        if (do_push)
            mem[wr_ptr] <= push_cmd;
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= (wr_ptr == PW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == PW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (push && !do_push)
                overflow <= 1'b1;  // sticky until reset
        end
    end

endmodule

//--- eeprom_pkg.sv
package eeprom_pkg;

    // device type code in the upper nibble of every control byte
    localparam logic [3:0] DEV_CODE = 4'b1010;

    // one host command, queued in cmd_fifo
    typedef struct packed {
        logic        is_read;
        logic [10:0] addr;
        logic [7:0]  wdata;   // ignored for reads
    } eeprom_cmd_t;

    // completion report, one per command
    typedef struct packed {
        logic        was_read;
        logic [10:0] addr;
        logic [7:0]  rdata;   // only meaningful for reads
        logic        ack_err; // slave NACKed a byte
    } eeprom_rsp_t;

    // first byte after a START
    typedef struct packed {
        logic [3:0] dev_code;
        logic [2:0] blk;      // address bits 10..8
        logic       rw;       // 1 = read
    } ctrl_byte_t;

    // same bus byte seen either as plain bits or as a control byte
    typedef union packed {
        logic [7:0] raw;
        ctrl_byte_t ctrl;
    } bus_byte_u;

endpackage
